//--- logic/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// Data and address width.
`define RV_WORD_W 32

// Major opcodes.
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

// ALU funct3.
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SR   3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// Branch funct3.
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// Load and store size.
`define RV_F3_B  3'b000
`define RV_F3_H  3'b001
`define RV_F3_W  3'b010
`define RV_F3_BU 3'b100
`define RV_F3_HU 3'b101

// Data RAM depth in words.
`define RV_RAM_WORDS 256

`endif

//--- logic/rv32i_pkg.sv
package rv32i_pkg;

    // One instruction word, viewed by format.
    // Register fields sit at the same bits in every view.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;

        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;

        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;

        // B, U and J immediates are scattered and come from raw bits.
        logic [31:0] raw;
    } rv32i_instr_u;

endpackage

//--- logic/ex_stage.sv
`include "rv32i_defs.svh"

module ex_stage
    import rv32i_pkg::*;
(
    input  rv32i_instr_u          instr_i,
    input  logic [`RV_WORD_W-1:0] pc_i,
    input  logic [`RV_WORD_W-1:0] rs1_data_i,
    input  logic [`RV_WORD_W-1:0] rs2_data_i,
    output logic [`RV_WORD_W-1:0] alu_out_o,
    output logic [`RV_WORD_W-1:0] br_target_o,
    output logic                  br_en_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [`RV_WORD_W-1:0] imm;
    logic [`RV_WORD_W-1:0] op_a;
    logic [`RV_WORD_W-1:0] op_b;
    logic [4:0]            shamt;
    logic                  alt;
    logic                  is_reg;
    logic                  is_imm;
    logic                  cond;
    logic [`RV_WORD_W-1:0] jalr_sum;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;
    assign is_reg = (opcode == `RV_OP_REG);
    assign is_imm = (opcode == `RV_OP_IMM);

    // Immediate by format.
    always_comb begin
        case (opcode)
            `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR:
                imm = {{20{instr_i.raw[31]}}, instr_i.i.imm};
            `RV_OP_STORE:
                imm = {{20{instr_i.raw[31]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            `RV_OP_BRANCH:
                imm = {{20{instr_i.raw[31]}}, instr_i.raw[7], instr_i.raw[30:25],
                       instr_i.raw[11:8], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm = {instr_i.raw[31:12], 12'b0};
            `RV_OP_JAL:
                imm = {{12{instr_i.raw[31]}}, instr_i.raw[19:12], instr_i.raw[20],
                       instr_i.raw[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    assign op_a  = (opcode == `RV_OP_AUIPC) ? pc_i : rs1_data_i;
    assign op_b  = (is_reg || opcode == `RV_OP_BRANCH) ? rs2_data_i : imm;
    assign shamt = op_b[4:0];

    // SUB for OP only; SRA for both OP and OP-IMM.
    assign alt = instr_i.r.funct7[5] & (is_reg | (is_imm & (funct3 == `RV_F3_SR)));

    always_comb begin
        alu_out_o = op_a + op_b;
        if (is_reg || is_imm) begin
            case (funct3)
                `RV_F3_ADD:  alu_out_o = alt ? op_a - op_b : op_a + op_b;
                `RV_F3_SLL:  alu_out_o = op_a << shamt;
                `RV_F3_SLT:  alu_out_o = {31'b0, $signed(op_a) < $signed(op_b)};
                `RV_F3_SLTU: alu_out_o = {31'b0, op_a < op_b};
                `RV_F3_XOR:  alu_out_o = op_a ^ op_b;
                `RV_F3_SR:   alu_out_o = alt ? $unsigned($signed(op_a) >>> shamt)
                                             : op_a >> shamt;
                `RV_F3_OR:   alu_out_o = op_a | op_b;
                default:     alu_out_o = op_a & op_b;
            endcase
        end
    end

    // Branch condition on the register operands.
    always_comb begin
        case (funct3)
            `RV_F3_BEQ:  cond = (rs1_data_i == rs2_data_i);
            `RV_F3_BNE:  cond = (rs1_data_i != rs2_data_i);
            `RV_F3_BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            `RV_F3_BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            `RV_F3_BLTU: cond = (rs1_data_i < rs2_data_i);
            `RV_F3_BGEU: cond = (rs1_data_i >= rs2_data_i);
            default:     cond = 1'b0;
        endcase
    end

    assign br_en_o = ((opcode == `RV_OP_BRANCH) && cond) ||
                     (opcode == `RV_OP_JAL) || (opcode == `RV_OP_JALR);

    assign jalr_sum = rs1_data_i + imm;

    always_comb begin
        if (opcode == `RV_OP_JALR) begin
            br_target_o = {jalr_sum[`RV_WORD_W-1:1], 1'b0};
        end else begin
            br_target_o = pc_i + imm;
        end
    end

endmodule

//--- logic/ex_mem_reg.sv
`include "rv32i_defs.svh"

module ex_mem_reg
    import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_i,
    input  logic                  valid_i,
    input  logic [`RV_WORD_W-1:0] pc_i,
    input  rv32i_instr_u          instr_i,
    input  logic [`RV_WORD_W-1:0] rs2_data_i,
    input  logic [`RV_WORD_W-1:0] alu_out_i,
    input  logic                  br_en_i,
    input  logic [`RV_WORD_W-1:0] br_target_i,
    output logic                  valid_o,
    output logic [`RV_WORD_W-1:0] pc_o,
    output rv32i_instr_u          instr_o,
    output logic [`RV_WORD_W-1:0] rs2_data_o,
    output logic [`RV_WORD_W-1:0] alu_out_o,
    output logic                  br_en_o,
    output logic [`RV_WORD_W-1:0] br_target_o
);

    // Control bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
            br_en_o <= 1'b0;
        end else if (load_i) begin
            valid_o <= valid_i;
            br_en_o <= br_en_i;
        end
    end

    // Payload holds while load is low.
    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_o        <= pc_i;
            instr_o     <= instr_i;
            rs2_data_o  <= rs2_data_i;
            alu_out_o   <= alu_out_i;
            br_target_o <= br_target_i;
        end
    end

endmodule

//--- logic/data_ram.sv
`include "rv32i_defs.svh"

module data_ram #(
    parameter int ADDR_W = $clog2(`RV_RAM_WORDS)
) (
    input  logic                  clk,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [3:0]            be_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic [`RV_WORD_W-1:0] wdata_i,
    output logic [`RV_WORD_W-1:0] rdata_o
);

    logic [`RV_WORD_W-1:0] mem [`RV_RAM_WORDS];

    // Byte-masked write.
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Registered read returns old data on a same-edge write.
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- logic/mem_access.sv
`include "rv32i_defs.svh"

module mem_access
    import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hold_i,
    input  logic                  valid_i,
    input  logic [`RV_WORD_W-1:0] pc_i,
    input  rv32i_instr_u          instr_i,
    input  logic [`RV_WORD_W-1:0] rs2_data_i,
    input  logic [`RV_WORD_W-1:0] alu_out_i,
    output logic                  wb_valid_o,
    output logic [4:0]            wb_rd_o,
    output logic [`RV_WORD_W-1:0] wb_data_o
);

    localparam int ADDR_W = $clog2(`RV_RAM_WORDS);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [1:0]            offset;
    logic                  is_load;
    logic                  writes_rd;
    logic                  we;
    logic [3:0]            be;
    logic [`RV_WORD_W-1:0] wdata;
    logic [`RV_WORD_W-1:0] rdata;
    logic [`RV_WORD_W-1:0] result;
    logic                  wb_is_load_q;
    logic [1:0]            offset_q;
    logic [2:0]            funct3_q;
    logic [`RV_WORD_W-1:0] result_q;
    logic [`RV_WORD_W-1:0] load_data;

    assign opcode  = instr_i.r.opcode;
    assign funct3  = instr_i.r.funct3;
    assign offset  = alu_out_i[1:0];
    assign is_load = (opcode == `RV_OP_LOAD);
    assign we      = valid_i && !hold_i && (opcode == `RV_OP_STORE);

    assign writes_rd = (opcode == `RV_OP_REG)  || (opcode == `RV_OP_IMM)   ||
                       (opcode == `RV_OP_LUI)  || (opcode == `RV_OP_AUIPC) ||
                       (opcode == `RV_OP_JAL)  || (opcode == `RV_OP_JALR)  || is_load;

    // Store lanes.
    always_comb begin
        case (funct3)
            `RV_F3_B: begin
                be    = 4'b0001 << offset;
                wdata = {4{rs2_data_i[7:0]}};
            end
            `RV_F3_H: begin
                be    = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{rs2_data_i[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = rs2_data_i;
            end
        endcase
    end

    data_ram u_data_ram (
        .clk     (clk),
        .en_i    (!hold_i),
        .we_i    (we),
        .be_i    (be),
        .addr_i  (alu_out_i[ADDR_W+1:2]),
        .wdata_i (wdata),
        .rdata_o (rdata)
    );

    // Result for everything but loads.
    always_comb begin
        case (opcode)
            `RV_OP_JAL, `RV_OP_JALR: result = pc_i + 32'd4;
            `RV_OP_LUI:              result = {instr_i.raw[31:12], 12'b0};
            default:                 result = alu_out_i;
        endcase
    end

    // MEM/WB register aligned with the RAM read.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else if (!hold_i) begin
            wb_valid_o <= valid_i && writes_rd && (instr_i.r.rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            wb_rd_o      <= instr_i.r.rd;
            wb_is_load_q <= is_load;
            offset_q     <= offset;
            funct3_q     <= funct3;
            result_q     <= result;
        end
    end

    // Load extract and extend.
    always_comb begin
        case (funct3_q)
            `RV_F3_B:  load_data = {{24{rdata[8*offset_q+7]}}, rdata[8*offset_q +: 8]};
            `RV_F3_BU: load_data = {24'b0, rdata[8*offset_q +: 8]};
            `RV_F3_H:  load_data = offset_q[1] ? {{16{rdata[31]}}, rdata[31:16]}
                                               : {{16{rdata[15]}}, rdata[15:0]};
            `RV_F3_HU: load_data = offset_q[1] ? {16'b0, rdata[31:16]}
                                               : {16'b0, rdata[15:0]};
            default:   load_data = rdata;
        endcase
    end

    assign wb_data_o = wb_is_load_q ? load_data : result_q;

endmodule

//--- logic/ex_mem_top.sv
`include "rv32i_defs.svh"

module ex_mem_top
    import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_i,
    input  logic                  stall_i,
    input  rv32i_instr_u          instr_i,
    input  logic [`RV_WORD_W-1:0] pc_i,
    input  logic [`RV_WORD_W-1:0] rs1_data_i,
    input  logic [`RV_WORD_W-1:0] rs2_data_i,
    output logic                  br_taken_o,
    output logic [`RV_WORD_W-1:0] br_target_o,
    output logic                  wb_valid_o,
    output logic [4:0]            wb_rd_o,
    output logic [`RV_WORD_W-1:0] wb_data_o
);

    logic [`RV_WORD_W-1:0] ex_alu_out;
    logic [`RV_WORD_W-1:0] ex_br_target;
    logic                  ex_br_en;

    logic                  em_valid;
    logic [`RV_WORD_W-1:0] em_pc;
    rv32i_instr_u          em_instr;
    logic [`RV_WORD_W-1:0] em_rs2_data;
    logic [`RV_WORD_W-1:0] em_alu_out;
    logic                  em_br_en;

    ex_stage u_ex_stage (
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .alu_out_o   (ex_alu_out),
        .br_target_o (ex_br_target),
        .br_en_o     (ex_br_en)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk         (clk),
        .rst         (rst),
        .load_i      (!stall_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .rs2_data_i  (rs2_data_i),
        .alu_out_i   (ex_alu_out),
        .br_en_i     (ex_br_en),
        .br_target_i (ex_br_target),
        .valid_o     (em_valid),
        .pc_o        (em_pc),
        .instr_o     (em_instr),
        .rs2_data_o  (em_rs2_data),
        .alu_out_o   (em_alu_out),
        .br_en_o     (em_br_en),
        .br_target_o (br_target_o)
    );

    // Only a valid instruction reports a taken branch.
    assign br_taken_o = em_valid & em_br_en;

    mem_access u_mem_access (
        .clk        (clk),
        .rst        (rst),
        .hold_i     (stall_i),
        .valid_i    (em_valid),
        .pc_i       (em_pc),
        .instr_i    (em_instr),
        .rs2_data_i (em_rs2_data),
        .alu_out_i  (em_alu_out),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

//--- tb/tb_ex_mem_top.sv
`include "rv32i_defs.svh"

module tb_ex_mem_top
    import rv32i_pkg::*;
();

    localparam int N_VEC = 43;
    localparam int N_COL = 9;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    logic                  stall;
    rv32i_instr_u          instr;
    logic [`RV_WORD_W-1:0] pc;
    logic [`RV_WORD_W-1:0] rs1_data;
    logic [`RV_WORD_W-1:0] rs2_data;
    logic                  br_taken;
    logic [`RV_WORD_W-1:0] br_target;
    logic                  wb_valid;
    logic [4:0]            wb_rd;
    logic [`RV_WORD_W-1:0] wb_data;

    // Nine words per instruction as in the file's column line.
    logic [`RV_WORD_W-1:0] vec [N_VEC*N_COL];

    // Vector index per pipeline slot with -1 for a bubble.
    int   flight_q[$];
    int   cur_idx;
    logic cur_stall;

    ex_mem_top dut (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid),
        .stall_i    (stall),
        .instr_i    (instr),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .br_taken_o (br_taken),
        .br_target_o(br_target),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data)
    );

    always #5 clk = ~clk;

    initial begin
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_word(input string name, input logic [`RV_WORD_W-1:0] exp,
                              input logic [`RV_WORD_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic bit work_in_flight();
        if (cur_idx >= 0 && !cur_stall) begin
            return 1'b1;
        end
        foreach (flight_q[k]) begin
            if (flight_q[k] >= 0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // Newest entry sits in EX/MEM and the older one in MEM/WB.
    task automatic check_outputs();
        int ex_idx;
        int wb_idx;
        ex_idx = (flight_q.size() >= 1) ? flight_q[$] : -1;
        wb_idx = (flight_q.size() == 2) ? flight_q[0] : -1;
        if (ex_idx >= 0) begin
            check_bit("br_taken_o", vec[ex_idx*N_COL+4][0], br_taken);
            if (vec[ex_idx*N_COL+4][0]) begin
                check_word("br_target_o", vec[ex_idx*N_COL+5], br_target);
            end
        end else begin
            check_bit("br_taken_o", 1'b0, br_taken);
        end
        if (wb_idx >= 0) begin
            check_bit("wb_valid_o", vec[wb_idx*N_COL+6][0], wb_valid);
            if (vec[wb_idx*N_COL+6][0]) begin
                check_rd("wb_rd_o", vec[wb_idx*N_COL+7][4:0], wb_rd);
                check_word("wb_data_o", vec[wb_idx*N_COL+8], wb_data);
            end
        end else begin
            check_bit("wb_valid_o", 1'b0, wb_valid);
        end
    endtask

    // Advance the model, drive the next inputs and check at the falling edge.
    task automatic apply_cycle(input logic stall_in, input int idx);
        int base;
        @(posedge clk);
        if (!cur_stall) begin
            flight_q.push_back(cur_idx);
            if (flight_q.size() > 2) begin
                void'(flight_q.pop_front());
            end
        end
        base = idx * N_COL;
        stall <= stall_in;
        valid <= (idx >= 0);
        if (idx >= 0) begin
            instr    <= vec[base];
            pc       <= vec[base+1];
            rs1_data <= vec[base+2];
            rs2_data <= vec[base+3];
        end
        cur_stall = stall_in;
        cur_idx   = idx;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        int idx;
        int guard;
        int stall_cnt;
        clk       = 1'b0;
        rst       = 1'b1;
        valid     = 1'b0;
        stall     = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_data  = '0;
        rs2_data  = '0;
        cur_idx   = -1;
        cur_stall = 1'b1;
        void'($urandom(32'hd896));
        $readmemh("tb/ex_mem_input.txt", vec);
        if ($isunknown(vec[N_VEC*N_COL-1])) begin
            $display("The stimulus file could not be read completely.");
            abort_run();
        end

        guard = 0;
        while (rst) begin
            @(posedge clk);
            guard++;
            if (guard > 20) begin
                $display("Timeout: reset was never released.");
                abort_run();
            end
        end

        // Idle pipe after reset with a jump to x1 on the bus and valid low.
        instr <= {20'h02000, 5'd1, `RV_OP_JAL};
        repeat (3) apply_cycle(1'b0, -1);

        for (idx = 0; idx < N_VEC; idx++) begin
            stall_cnt = 0;
            while (($urandom % 4 == 0) && stall_cnt < 3) begin
                // Another instruction on the bus must not enter the pipe.
                apply_cycle(1'b1, (idx + 1) % N_VEC);
                stall_cnt++;
            end
            apply_cycle(1'b0, idx);
        end

        guard = 0;
        while (work_in_flight()) begin
            apply_cycle(1'b0, -1);
            guard++;
            if (guard > 8) begin
                $display("Timeout: the last instructions never reached writeback.");
                abort_run();
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- tb/ex_mem_input.txt
// instr pc rs1 rs2 | br_taken br_target | wb_valid wb_rd wb_data (all hex)
// br_target is checked only when br_taken is 1, rd and data only when wb_valid is 1
002081B3 00000100 00000005 00000007 0 00000000 1 03 0000000C
40208233 00000104 00000005 00000007 0 00000000 1 04 FFFFFFFE
002092B3 00000108 80000001 00000024 0 00000000 1 05 00000010
4020D333 0000010C 80000000 00000004 0 00000000 1 06 F8000000
0020A433 00000110 FFFFFFFF 00000001 0 00000000 1 08 00000001
0020B4B3 00000114 FFFFFFFF 00000001 0 00000000 1 09 00000000
0020E5B3 00000118 F0F0F0F0 0F0000FF 0 00000000 1 0B FFF0F0FF
0020F633 0000011C F0F0F0F0 FF00FF00 0 00000000 1 0C F000F000
FFD08693 00000120 00000010 00000000 0 00000000 1 0D 0000000D
4080D713 00000124 80001234 00000000 0 00000000 1 0E FF800012
00508013 00000128 00000001 00000000 0 00000000 0 00 00000000
12345837 0000012C 00000000 00000000 0 00000000 1 10 12345000
FFFFF897 00000200 00000000 00000000 0 00000000 1 11 FFFFF200
00208863 00000300 00000005 00000005 1 00000310 0 00 00000000
00208863 00000304 00000005 00000006 0 00000000 0 00 00000000
00209863 00000308 00000001 00000002 1 00000318 0 00 00000000
00209863 0000030C 00000003 00000003 0 00000000 0 00 00000000
FE20CCE3 00000310 FFFFFFFF 00000001 1 00000308 0 00 00000000
0020C863 00000314 00000001 FFFFFFFF 0 00000000 0 00 00000000
0020D863 00000318 00000002 00000002 1 00000328 0 00 00000000
0020D863 0000031C FFFFFFFF 00000000 0 00000000 0 00 00000000
0020E863 00000320 00000001 FFFFFFFF 1 00000330 0 00 00000000
0020E863 00000324 FFFFFFFF 00000001 0 00000000 0 00 00000000
0020F863 00000328 FFFFFFFF 00000001 1 00000338 0 00 00000000
0020F863 0000032C 00000001 FFFFFFFF 0 00000000 0 00 00000000
020000EF 00000400 00000000 00000000 1 00000420 1 01 00000404
003082E7 00000500 00001000 00000000 1 00001002 1 05 00000504
0020A023 00000600 00000040 11223344 0 00000000 0 00 00000000
002080A3 00000604 00000040 000000AA 0 00000000 0 00 00000000
002081A3 00000608 00000040 000000BB 0 00000000 0 00 00000000
00208023 0000060C 00000040 000000CC 0 00000000 0 00 00000000
0000A903 00000610 00000040 00000000 0 00000000 1 12 BB22AACC
00108983 00000614 00000040 00000000 0 00000000 1 13 FFFFFFAA
0030CA03 00000618 00000040 00000000 0 00000000 1 14 000000BB
0020A023 0000061C 00000044 55667788 0 00000000 0 00 00000000
00209123 00000620 00000044 0000F00F 0 00000000 0 00 00000000
00209023 00000624 00000044 00008001 0 00000000 0 00 00000000
00208123 00000628 00000044 00000099 0 00000000 0 00 00000000
00009B83 0000062C 00000044 00000000 0 00000000 1 17 FFFF8001
0020DC03 00000630 00000044 00000000 0 00000000 1 18 0000F099
0000AC83 00000634 00000044 00000000 0 00000000 1 19 F0998001
0020A023 00000638 00000048 CAFEF00D 0 00000000 0 00 00000000
0000AD03 0000063C 00000048 00000000 0 00000000 1 1A CAFEF00D

//--- list.f
+incdir+logic
logic/rv32i_pkg.sv
logic/ex_stage.sv
logic/ex_mem_reg.sv
logic/data_ram.sv
logic/mem_access.sv
logic/ex_mem_top.sv
tb/tb_ex_mem_top.sv

//--- Bender.yml
package:
  name: rv32i_ex_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv32i_pkg.sv
      - logic/ex_stage.sv
      - logic/ex_mem_reg.sv
      - logic/data_ram.sv
      - logic/mem_access.sv
      - logic/ex_mem_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/tb_ex_mem_top.sv
